// File: verilog/ascon_pkg.sv
// ascon_pkg: shared types, register map and encodings for the Ascon-AEAD128 engine
package ascon_pkg;

    localparam int LANE_W      = 64;     // bits per state word
    localparam int BLOCK_BYTES = 16;     // rate block in bytes

    typedef logic [127:0] block_t;       // key, nonce, ad, ptx, ct, tag
    typedef logic [63:0]  lane_t;        // one ascon word
    typedef logic [319:0] state_t;       // lane 0 in the low bits
    typedef logic [3:0]   len_t;         // byte count, 0..15
    typedef logic [3:0]   round_t;       // round index, 0..11
    typedef logic [7:0]   bus_addr_t;    // [7:4] register, [3:0] byte
    typedef logic [7:0]   bus_data_t;

    // register map, upper address nibble
    localparam logic [3:0] REG_KEY   = 4'h0;
    localparam logic [3:0] REG_NONCE = 4'h1;
    localparam logic [3:0] REG_AD    = 4'h2;
    localparam logic [3:0] REG_PTX   = 4'h3;
    localparam logic [3:0] REG_LEN   = 4'h4;  // byte 0 ad_len, byte 1 msg_len
    localparam logic [3:0] REG_CTRL  = 4'h5;  // wr bit0 go, rd {done, busy}
    localparam logic [3:0] REG_CT    = 4'h6;
    localparam logic [3:0] REG_TAG   = 4'h7;

    localparam lane_t ASCON_IV = 64'h00001000808c0001;  // aead128 iv

    // p^12 runs 0..11, p^8 runs 4..11
    localparam round_t ROUNDS_A_START = 4'd0;
    localparam round_t ROUNDS_B_START = 4'd4;
    localparam round_t ROUND_LAST     = 4'd11;

    typedef enum logic [3:0] {
        OP_IDLE, OP_LOAD, OP_ROUND, OP_KEY_INIT, OP_ABSORB_AD,
        OP_SEPARATE, OP_ABSORB_MSG, OP_KEY_FINAL, OP_TAG
    } dp_op_t;

    typedef enum logic [2:0] {
        S_IDLE, S_INIT, S_AD, S_MSG, S_FINAL, S_DONE
    } seq_state_t;

    typedef struct packed {
        block_t key;
        block_t nonce;
        block_t ad;
        block_t ptx;
        len_t   ad_len;
        len_t   msg_len;
    } host_cfg_t;

    typedef struct packed {
        block_t ct;
        block_t tag;
    } core_result_t;

endpackage

// File: verilog/host_regs.sv
// host_regs: byte-addressed register bank for engine inputs, status and results
`timescale 1ns/10ps

module host_regs (
    input  logic                    crypt_clk,
    input  logic                    resetn,
    input  ascon_pkg::bus_addr_t    bus_addr,
    input  ascon_pkg::bus_data_t    bus_wdata,
    input  logic                    bus_wr,
    input  logic                    bus_rd,
    input  logic                    busy,
    input  logic                    done_pulse,
    input  ascon_pkg::core_result_t result,
    output ascon_pkg::bus_data_t    bus_rdata,
    output ascon_pkg::host_cfg_t    cfg,
    output ascon_pkg::len_t         ad_len,
    output logic                    go
);
    import ascon_pkg::*;

    logic [3:0]   reg_sel;     // register index
    logic [3:0]   byte_sel;    // byte within register
    logic [6:0]   bit_base;    // lsb of addressed byte
    logic         locked;      // inputs frozen while running
    logic         done;
    core_result_t res_q;       // latched ct and tag
    bus_data_t    rd_mux;

    assign reg_sel  = bus_addr[7:4];
    assign byte_sel = bus_addr[3:0];
    assign bit_base = {byte_sel, 3'b000};
    assign locked   = busy | go;   // go cycle counts as busy too
    assign ad_len   = cfg.ad_len;

    // input registers
    always_ff @(posedge crypt_clk) begin
        if (bus_wr && !locked) begin
            case (reg_sel)
                REG_KEY:   cfg.key[bit_base +: 8]   <= bus_wdata;
                REG_NONCE: cfg.nonce[bit_base +: 8] <= bus_wdata;
                REG_AD:    cfg.ad[bit_base +: 8]    <= bus_wdata;
                REG_PTX:   cfg.ptx[bit_base +: 8]   <= bus_wdata;
                REG_LEN: begin
                    if (byte_sel == 4'd0)
                        cfg.ad_len <= bus_wdata[3:0];
                    else if (byte_sel == 4'd1)
                        cfg.msg_len <= bus_wdata[3:0];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge crypt_clk) begin
        if (done_pulse)
            res_q <= result;   // hold until the next run completes
    end

    always_ff @(posedge crypt_clk or negedge resetn) begin
        if (!resetn) begin
            go        <= 1'b0;
            done      <= 1'b0;
            bus_rdata <= '0;
        end else begin
            go <= bus_wr && !locked && (reg_sel == REG_CTRL) &&
                  (byte_sel == 4'd0) && bus_wdata[0];
            if (go)
                done <= 1'b0;          // new run clears old status
            else if (done_pulse)
                done <= 1'b1;
            if (bus_rd)
                bus_rdata <= rd_mux;   // held until next read
        end
    end

    // read side
    always_comb begin
        rd_mux = '0;
        case (reg_sel)
            REG_KEY:   rd_mux = cfg.key[bit_base +: 8];
            REG_NONCE: rd_mux = cfg.nonce[bit_base +: 8];
            REG_AD:    rd_mux = cfg.ad[bit_base +: 8];
            REG_PTX:   rd_mux = cfg.ptx[bit_base +: 8];
            REG_LEN: begin
                if (byte_sel == 4'd0)
                    rd_mux = {4'd0, cfg.ad_len};
                else if (byte_sel == 4'd1)
                    rd_mux = {4'd0, cfg.msg_len};
            end
            REG_CTRL:  rd_mux = {6'd0, done, busy};
            REG_CT:    rd_mux = res_q.ct[bit_base +: 8];
            REG_TAG:   rd_mux = res_q.tag[bit_base +: 8];
            default: ;
        endcase
    end

endmodule

// File: verilog/ascon_sequencer.sv
// ascon_sequencer: FSM that orders init, associated data, message, finalization and done
`timescale 1ns/10ps

module ascon_sequencer (
    input  logic              crypt_clk,
    input  logic              resetn,
    input  logic              go,
    input  ascon_pkg::len_t   ad_len,
    input  logic              round_last,
    output ascon_pkg::dp_op_t op,
    output logic              round_load,
    output ascon_pkg::round_t round_start,
    output logic              busy,
    output logic              done_pulse,
    output logic              trigger
);
    import ascon_pkg::*;

    // position inside a phase
    typedef enum logic [1:0] {STEP_OPEN, STEP_ROUNDS, STEP_CLOSE} step_t;

    seq_state_t state, state_n;
    step_t      step, step_n;

    always_ff @(posedge crypt_clk or negedge resetn) begin
        if (!resetn) begin
            state <= S_IDLE;
            step  <= STEP_OPEN;
        end else begin
            state <= state_n;
            step  <= step_n;
        end
    end

    always_comb begin
        state_n     = state;
        step_n      = step;
        op          = OP_IDLE;
        round_load  = 1'b0;
        round_start = ROUNDS_A_START;
        done_pulse  = 1'b0;
        case (state)
            S_IDLE: begin
                if (go) begin
                    op         = OP_LOAD;
                    round_load = 1'b1;     // p^12 from round 0
                    state_n    = S_INIT;
                    step_n     = STEP_ROUNDS;
                end
            end
            S_INIT: begin
                if (step == STEP_ROUNDS) begin
                    op = OP_ROUND;
                    if (round_last)
                        step_n = STEP_CLOSE;
                end else begin
                    op      = OP_KEY_INIT;
                    state_n = S_AD;
                    // no AD, separate right away
                    step_n  = (ad_len != '0) ? STEP_OPEN : STEP_CLOSE;
                end
            end
            S_AD: begin
                case (step)
                    STEP_OPEN: begin
                        op          = OP_ABSORB_AD;
                        round_load  = 1'b1;
                        round_start = ROUNDS_B_START;   // p^8
                        step_n      = STEP_ROUNDS;
                    end
                    STEP_ROUNDS: begin
                        op = OP_ROUND;
                        if (round_last)
                            step_n = STEP_CLOSE;
                    end
                    default: begin
                        op      = OP_SEPARATE;
                        state_n = S_MSG;
                        step_n  = STEP_OPEN;
                    end
                endcase
            end
            S_MSG: begin
                if (step == STEP_OPEN) begin
                    op     = OP_ABSORB_MSG;   // single final block
                    step_n = STEP_CLOSE;
                end else begin
                    op         = OP_KEY_FINAL;
                    round_load = 1'b1;
                    state_n    = S_FINAL;
                    step_n     = STEP_ROUNDS;
                end
            end
            S_FINAL: begin
                if (step == STEP_ROUNDS) begin
                    op = OP_ROUND;
                    if (round_last)
                        step_n = STEP_CLOSE;
                end else begin
                    op      = OP_TAG;
                    state_n = S_DONE;
                end
            end
            S_DONE: begin
                done_pulse = 1'b1;
                state_n    = S_IDLE;
                step_n     = STEP_OPEN;
            end
            default: state_n = S_IDLE;
        endcase
    end

    assign busy    = (state != S_IDLE);
    // capture window covers AD onwards
    assign trigger = (state == S_AD) || (state == S_MSG) ||
                     (state == S_FINAL) || (state == S_DONE);

endmodule

// File: verilog/round_counter.sv
// round_counter: round index for the p^12 and p^8 permutations
`timescale 1ns/10ps

module round_counter (
    input  logic              crypt_clk,
    input  logic              resetn,
    input  logic              round_load,
    input  ascon_pkg::round_t round_start,
    output ascon_pkg::round_t round,
    output logic              round_last
);
    import ascon_pkg::*;

    always_ff @(posedge crypt_clk or negedge resetn) begin
        if (!resetn)
            round <= '0;
        else if (round_load)
            round <= round_start;   // 0 for p^12, 4 for p^8
        else
            round <= round + 1'b1;
    end

    // both permutations end on the same index
    assign round_last = (round == ROUND_LAST);

endmodule

// File: verilog/ascon_datapath.sv
// ascon_datapath: 320-bit Ascon state with round function, absorb and key-mix steps
`timescale 1ns/10ps

module ascon_datapath (
    input  logic                    crypt_clk,
    input  logic                    resetn,
    input  ascon_pkg::dp_op_t       op,
    input  ascon_pkg::round_t       round,
    input  ascon_pkg::host_cfg_t    cfg,
    output ascon_pkg::core_result_t result
);
    import ascon_pkg::*;

    state_t s;   // lane i at s[64*i +: 64]

    function automatic lane_t rotr(lane_t x, int n);
        return (x >> n) | (x << (LANE_W - n));
    endfunction

    // keep bytes below len, zero the rest
    function automatic block_t mask_block(block_t d, len_t len);
        block_t m;
        m = '0;
        for (int b = 0; b < BLOCK_BYTES; b++) begin
            if (b < int'(len))
                m[8*b +: 8] = d[8*b +: 8];
        end
        return m;
    endfunction

    // 0x01 pad byte sits right after the data
    function automatic block_t pad_block(block_t d, len_t len);
        block_t one;
        one = block_t'(1) << {len, 3'b000};
        return mask_block(d, len) | one;
    endfunction

    function automatic state_t ascon_round(state_t st, round_t r);
        lane_t x0, x1, x2, x3, x4;
        lane_t t0, t1, t2, t3, t4;
        x0 = st[0*LANE_W +: LANE_W];
        x1 = st[1*LANE_W +: LANE_W];
        x2 = st[2*LANE_W +: LANE_W] ^ {56'd0, ~r, r};   // const {15-r, r}
        x3 = st[3*LANE_W +: LANE_W];
        x4 = st[4*LANE_W +: LANE_W];
        // bitsliced s-box
        x0 ^= x4;
        x4 ^= x3;
        x2 ^= x1;
        t0 = ~x0 & x1;
        t1 = ~x1 & x2;
        t2 = ~x2 & x3;
        t3 = ~x3 & x4;
        t4 = ~x4 & x0;
        x0 ^= t1;
        x1 ^= t2;
        x2 ^= t3;
        x3 ^= t4;
        x4 ^= t0;
        x1 ^= x0;
        x0 ^= x4;
        x3 ^= x2;
        x2 = ~x2;
        // linear diffusion per lane
        x0 ^= rotr(x0, 19) ^ rotr(x0, 28);
        x1 ^= rotr(x1, 61) ^ rotr(x1, 39);
        x2 ^= rotr(x2, 1) ^ rotr(x2, 6);
        x3 ^= rotr(x3, 10) ^ rotr(x3, 17);
        x4 ^= rotr(x4, 7) ^ rotr(x4, 41);
        return {x4, x3, x2, x1, x0};
    endfunction

    always_ff @(posedge crypt_clk) begin
        case (op)
            OP_LOAD:       s <= {cfg.nonce, cfg.key, ASCON_IV};
            OP_ROUND:      s <= ascon_round(s, round);
            OP_KEY_INIT:   s <= s ^ {cfg.key, 192'd0};           // lanes 3,4
            OP_ABSORB_AD:  s <= s ^ {192'd0, pad_block(cfg.ad, cfg.ad_len)};
            OP_SEPARATE:   s <= s ^ {1'b1, 319'd0};              // domain bit, msb of lane 4
            OP_ABSORB_MSG: s <= s ^ {192'd0, pad_block(cfg.ptx, cfg.msg_len)};
            OP_KEY_FINAL:  s <= s ^ {64'd0, cfg.key, 128'd0};    // lanes 2,3
            default: ;                                           // idle, tag hold
        endcase
    end

    always_ff @(posedge crypt_clk or negedge resetn) begin
        if (!resetn) begin
            result <= '0;
        end else begin
            if (op == OP_ABSORB_MSG)
                result.ct <= mask_block(s[127:0] ^ cfg.ptx, cfg.msg_len);   // pre-absorb state
            if (op == OP_TAG)
                result.tag <= s[319:192] ^ cfg.key;
        end
    end

endmodule

// File: verilog/ascon_engine_top.sv
// ascon_engine_top: register-mapped Ascon-AEAD128 encryption engine
`timescale 1ns/10ps

module ascon_engine_top (
    input  logic                 crypt_clk,
    input  logic                 resetn,
    input  ascon_pkg::bus_addr_t bus_addr,
    input  ascon_pkg::bus_data_t bus_wdata,
    input  logic                 bus_wr,
    input  logic                 bus_rd,
    output ascon_pkg::bus_data_t bus_rdata,
    output logic                 trigger
);
    import ascon_pkg::*;

    host_cfg_t    cfg;
    core_result_t result;
    len_t         ad_len;
    dp_op_t       op;
    round_t       round_start;
    round_t       round;
    logic         go;
    logic         busy;
    logic         done_pulse;
    logic         round_load;
    logic         round_last;

    host_regs i_host_regs (
        .crypt_clk  (crypt_clk),
        .resetn     (resetn),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .busy       (busy),
        .done_pulse (done_pulse),
        .result     (result),
        .bus_rdata  (bus_rdata),
        .cfg        (cfg),
        .ad_len     (ad_len),
        .go         (go)
    );

    ascon_sequencer i_ascon_sequencer (
        .crypt_clk   (crypt_clk),
        .resetn      (resetn),
        .go          (go),
        .ad_len      (ad_len),
        .round_last  (round_last),
        .op          (op),
        .round_load  (round_load),
        .round_start (round_start),
        .busy        (busy),
        .done_pulse  (done_pulse),
        .trigger     (trigger)
    );

    round_counter i_round_counter (
        .crypt_clk   (crypt_clk),
        .resetn      (resetn),
        .round_load  (round_load),
        .round_start (round_start),
        .round       (round),
        .round_last  (round_last)
    );

    ascon_datapath i_ascon_datapath (
        .crypt_clk (crypt_clk),
        .resetn    (resetn),
        .op        (op),
        .round     (round),
        .cfg       (cfg),
        .result    (result)
    );

endmodule

// File: verification/clock_gen.sv
// clock_gen: testbench clock and active-low reset source
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD       = 100,   // ns
    parameter int RESET_CYCLES = 10
) (
    output logic crypt_clk,
    output logic resetn
);

    initial begin
        crypt_clk = 1'b0;
        forever #(PERIOD / 2) crypt_clk = ~crypt_clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge crypt_clk);
        @(negedge crypt_clk);
        resetn = 1'b1;   // release away from the active edge
    end

endmodule

// File: verification/tb_ascon_engine.sv
// tb_ascon_engine: pattern-file driven testbench for the Ascon-AEAD128 engine
`timescale 1ns/10ps

module tb_ascon_engine;
    import ascon_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 400;   // bus traffic plus about 40 engine cycles
    localparam int POLL_LIMIT   = 60;

    // one line of the pattern file
    typedef struct packed {
        host_cfg_t    cfg;
        logic         kat;   // expected values come from the file
        core_result_t exp;
    } pattern_t;

    // ascon s-box, column bit of x0 is the msb
    localparam logic [4:0] SBOX [32] = '{
        5'h04, 5'h0b, 5'h1f, 5'h14, 5'h1a, 5'h15, 5'h09, 5'h02,
        5'h1b, 5'h05, 5'h08, 5'h12, 5'h1d, 5'h03, 5'h06, 5'h1c,
        5'h1e, 5'h13, 5'h07, 5'h0e, 5'h00, 5'h0d, 5'h11, 5'h18,
        5'h10, 5'h0c, 5'h01, 5'h19, 5'h16, 5'h0a, 5'h0f, 5'h17
    };

    logic      crypt_clk;
    logic      resetn;
    bus_addr_t bus_addr;
    bus_data_t bus_wdata;
    logic      bus_wr;
    logic      bus_rd;
    bus_data_t bus_rdata;
    logic      trigger;

    pattern_t  patterns[$];
    int        checks;
    int        errors;
    bit        loaded;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
        .crypt_clk (crypt_clk),
        .resetn    (resetn)
    );

    ascon_engine_top i_ascon_engine_top (
        .crypt_clk (crypt_clk),
        .resetn    (resetn),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd),
        .bus_rdata (bus_rdata),
        .trigger   (trigger)
    );

    function automatic lane_t ror(lane_t x, int n);
        return lane_t'({x, x} >> n);
    endfunction

    function automatic lane_t mix(lane_t x, int a, int c);
        return x ^ ror(x, a) ^ ror(x, c);
    endfunction

    // last nr rounds of the 12-round schedule
    function automatic state_t permute(state_t st, int nr);
        lane_t      x [5];
        lane_t      y [5];
        logic [4:0] col;
        int         r;
        int         i;
        int         b;
        for (r = 12 - nr; r < 12; r++) begin
            for (i = 0; i < 5; i++)
                x[i] = st[64*i +: 64];
            x[2][7:0] = x[2][7:0] ^ 8'((15 - r) * 16 + r);   // round constant
            for (b = 0; b < 64; b++) begin
                col = SBOX[{x[0][b], x[1][b], x[2][b], x[3][b], x[4][b]}];
                {y[0][b], y[1][b], y[2][b], y[3][b], y[4][b]} = col;
            end
            st = {mix(y[4], 7, 41), mix(y[3], 10, 17), mix(y[2], 1, 6),
                  mix(y[1], 61, 39), mix(y[0], 19, 28)};
        end
        return st;
    endfunction

    // bytes below len kept, optional 0x01 right after them
    function automatic block_t keep_bytes(block_t d, len_t len, bit pad);
        block_t o;
        int     j;
        o = '0;
        for (j = 0; j < 16; j++) begin
            if (j < int'(len))
                o[8*j +: 8] = d[8*j +: 8];
            else if (pad && j == int'(len))
                o[8*j +: 8] = 8'h01;
        end
        return o;
    endfunction

    // reference encryption, single AD block and single message block
    function automatic core_result_t model_encrypt(host_cfg_t c);
        state_t       s;
        core_result_t r;
        s = {c.nonce, c.key, 64'h00001000808c0001};
        s = permute(s, 12);
        s[319:192] = s[319:192] ^ c.key;
        if (c.ad_len != 4'd0)
            s = permute({s[319:128], s[127:0] ^ keep_bytes(c.ad, c.ad_len, 1'b1)}, 8);
        s[319] = ~s[319];   // domain separation
        r.ct = keep_bytes(s[127:0] ^ c.ptx, c.msg_len, 1'b0);
        s[127:0] = s[127:0] ^ keep_bytes(c.ptx, c.msg_len, 1'b1);
        s[255:128] = s[255:128] ^ c.key;
        s = permute(s, 12);
        r.tag = s[319:192] ^ c.key;
        return r;
    endfunction

    task automatic check(input string name, input block_t got, input block_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic bus_write(input bus_addr_t a, input bus_data_t d);
        @(posedge crypt_clk);
        bus_addr  <= a;
        bus_wdata <= d;
        bus_wr    <= 1'b1;
        @(posedge crypt_clk);
        bus_wr    <= 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t a, output bus_data_t d);
        @(posedge crypt_clk);
        bus_addr <= a;
        bus_rd   <= 1'b1;
        @(posedge crypt_clk);
        bus_rd   <= 1'b0;
        @(negedge crypt_clk);
        d = bus_rdata;   // settled half a cycle after capture
    endtask

    task automatic write_block(input logic [3:0] reg_idx, input block_t v);
        for (int j = 0; j < 16; j++)
            bus_write({reg_idx, 4'(j)}, v[8*j +: 8]);
    endtask

    task automatic read_block(input logic [3:0] reg_idx, output block_t v);
        bus_data_t d;
        for (int j = 0; j < 16; j++) begin
            bus_read({reg_idx, 4'(j)}, d);
            v[8*j +: 8] = d;
        end
    endtask

    task automatic load_patterns();
        int       fd;
        int       n;
        string    line;
        block_t   key, nonce, ad, ptx, ct, tag;
        len_t     ad_len, msg_len;
        logic     kat;
        pattern_t p;
        fd = $fopen("verification/ascon_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("pattern file verification/ascon_patterns.txt could not be opened");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == 8'h23)   // blank or '#' line
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        key, nonce, ad, ptx, ad_len, msg_len, kat, ct, tag);
            if (n != 9) begin
                errors++;
                $display("pattern line %0d is malformed", patterns.size() + 1);
                continue;
            end
            p.cfg.key     = key;
            p.cfg.nonce   = nonce;
            p.cfg.ad      = ad;
            p.cfg.ptx     = ptx;
            p.cfg.ad_len  = ad_len;
            p.cfg.msg_len = msg_len;
            p.kat         = kat;
            p.exp.ct      = ct;
            p.exp.tag     = tag;
            patterns.push_back(p);
        end
        $fclose(fd);
    endtask

    task automatic run_pattern(input int n, input pattern_t p);
        core_result_t exp;
        block_t       got_ct;
        block_t       got_tag;
        bus_data_t    st;
        int           polls;
        int           err_before;
        bit           saw_trigger;
        exp        = p.kat ? p.exp : model_encrypt(p.cfg);
        err_before = errors;
        write_block(REG_KEY, p.cfg.key);
        write_block(REG_NONCE, p.cfg.nonce);
        write_block(REG_AD, p.cfg.ad);
        write_block(REG_PTX, p.cfg.ptx);
        bus_write({REG_LEN, 4'd0}, {4'd0, p.cfg.ad_len});
        bus_write({REG_LEN, 4'd1}, {4'd0, p.cfg.msg_len});
        bus_write({REG_CTRL, 4'd0}, 8'h01);
        // both land while busy, engine must ignore them
        bus_write({REG_CTRL, 4'd0}, 8'h01);
        bus_write({REG_KEY, 4'd0}, ~p.cfg.key[7:0]);
        st          = '0;
        polls       = 0;
        saw_trigger = 1'b0;
        while (st[1] == 1'b0 && polls < POLL_LIMIT) begin
            bus_read({REG_CTRL, 4'd0}, st);
            if (trigger)
                saw_trigger = 1'b1;
            polls++;
        end
        if (st[1] == 1'b0) begin
            errors++;
            $display("test %0d: done bit never set after %0d status reads", n, polls);
        end else begin
            check("status", block_t'(st), block_t'(8'h02));   // done, not busy
            check("trigger", block_t'(trigger), '0);
            if (!saw_trigger) begin
                errors++;
                $display("test %0d: trigger never seen high during the run", n);
            end
        end
        read_block(REG_CT, got_ct);
        read_block(REG_TAG, got_tag);
        check("ct", got_ct, exp.ct);
        check("tag", got_tag, exp.tag);
        $display("test %0d: ad_len %0d msg_len %0d %s", n, p.cfg.ad_len, p.cfg.msg_len,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        bus_data_t st;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_wr    = 1'b0;
        bus_rd    = 1'b0;
        checks    = 0;
        errors    = 0;
        load_patterns();
        loaded = 1'b1;
        if (patterns.size() == 0) begin
            errors++;
            $display("no patterns were loaded");
        end
        wait (resetn);
        bus_read({REG_CTRL, 4'd0}, st);
        check("status", block_t'(st), '0);
        check("trigger", block_t'(trigger), '0);
        $display("test 0: reset state %s", (errors == 0) ? "ok" : "mismatch");
        foreach (patterns[i])
            run_pattern(i + 1, patterns[i]);
        $display("%0d tests, %0d checks, %0d errors", patterns.size() + 1, checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // watchdog sized from the number of patterns
    initial begin
        int limit;
        wait (loaded);
        limit = (patterns.size() + 2) * TEST_CYCLES + RESET_CYCLES;
        repeat (limit) @(posedge crypt_clk);
        $display("timeout: run still going after %0d clock cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: verification/ascon_patterns.txt
# key nonce ad ptx ad_len msg_len kat ct tag, 128-bit fields with byte 0 rightmost
# kat 1 compares ct and tag with the columns here, kat 0 uses the testbench reference model
0f0e0d0c0b0a09080706050403020100 1f1e1d1c1b1a19181716151413121110 00000000000000000000000000000000 00000000000000000000000000000000 0 0 1 00000000000000000000000000000000 c62e8bee468ff66b31c9be1182279c4f
0f0e0d0c0b0a09080706050403020100 1f1e1d1c1b1a19181716151413121110 3f3e3d3c3b3a39383736353433323130 2f2e2d2c2b2a29282726252423222120 5 7 0 00000000000000000000000000000000 00000000000000000000000000000000
0f0e0d0c0b0a09080706050403020100 1f1e1d1c1b1a19181716151413121110 3f3e3d3c3b3a39383736353433323130 2f2e2d2c2b2a29282726252423222120 0 7 0 00000000000000000000000000000000 00000000000000000000000000000000
0123456789abcdeffedcba9876543210 00112233445566778899aabbccddeeff deadbeefcafef00d0badc0de12345678 5a5a5a5aa5a5a5a53c3c3c3cc3c3c3c3 f f 0 00000000000000000000000000000000 00000000000000000000000000000000
0123456789abcdeffedcba9876543210 00112233445566778899aabbccddeeff deadbeefcafef00d0badc0de12345678 5a5a5a5aa5a5a5a53c3c3c3cc3c3c3c3 1 0 0 00000000000000000000000000000000 00000000000000000000000000000000
ffeeddccbbaa99887766554433221100 0f1e2d3c4b5a69788796a5b4c3d2e1f0 00000000000000000000000000000000 6d6573736167652d626c6f636b2d3031 0 3 0 00000000000000000000000000000000 00000000000000000000000000000000
13579bdf02468ace13579bdf02468ace 89abcdef012345670123456789abcdef 112233445566778899aabbccddeeff00 0f1e2d3c4b5a69788796a5b4c3d2e1f0 c e 0 00000000000000000000000000000000 00000000000000000000000000000000
a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a 00000000000000000000000000000001 7766554433221100ffeeddccbbaa9988 00000000000000000000000000000000 8 1 0 00000000000000000000000000000000 00000000000000000000000000000000

// File: list.f
verilog/ascon_pkg.sv
verilog/host_regs.sv
verilog/ascon_sequencer.sv
verilog/round_counter.sv
verilog/ascon_datapath.sv
verilog/ascon_engine_top.sv
verification/clock_gen.sv
verification/tb_ascon_engine.sv

// File: Makefile
# Verilator build and run for the Ascon-AEAD128 engine testbench

VERILATOR ?= verilator
TOP       ?= tb_ascon_engine
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TESTS PASSED'

clean:
	rm -rf $(OBJ_DIR)
